// File: list.f
source/mem_pkg.sv
source/mem_req_align.sv
source/mem_banked_ram.sv
source/mem_load_align.sv
source/mem_subsys_top.sv
verification/mem_subsys_asserts.sv
verification/mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
# build and run the data memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mem_subsys_tb -f list.f &&
./obj_dir/Vmem_subsys_tb | tee /dev/stderr | grep -qx "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verification/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    mem_pkg::mem_req_t req;
    logic              rsp_valid;
    mem_pkg::mem_rsp_t rsp;

    logic [7:0]        ref_mem [1024];  // byte model, wraps at 1 KiB
    mem_pkg::mem_req_t stim_q [$];      // requests for back-to-back streams
    int                checks;
    int                val_errs;
    int                lost_rsps;

    mem_subsys_top uut
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic mem_pkg::mem_req_t make_req
    (
        input logic [31:0]        addr,
        input logic [31:0]        wdata,
        input mem_pkg::mem_size_t size,
        input logic               write,
        input logic               uns
    );
        mem_pkg::mem_req_t r;
        r.addr          = addr;
        r.wdata         = wdata;
        r.size          = size;
        r.write         = write;
        r.unsigned_load = uns;
        return r;
    endfunction

    // expected response by the little-endian byte rules, updates the model on stores
    task automatic model_access(input mem_pkg::mem_req_t r, output mem_pkg::mem_rsp_t e);
        int          nbytes;
        int          k;
        logic [9:0]  a;
        logic [31:0] val;
        nbytes = (r.size == mem_pkg::size_byte) ? 1 : (r.size == mem_pkg::size_half) ? 2 : 4;
        e      = '0;
        val    = '0;
        if ((r.addr % nbytes) != 0)
        begin
            e.err = 1'b1;  // misaligned, memory untouched
        end
        else
        begin
            for (k = 0; k < nbytes; k++)
            begin
                a = r.addr[9:0] + 10'(k);
                if (r.write)
                begin
                    ref_mem[a] = r.wdata[8*k +: 8];
                end
                else
                begin
                    val[8*k +: 8] = ref_mem[a];
                end
            end
            if (!r.write)
            begin
                if (nbytes == 1)
                begin
                    e.rdata = r.unsigned_load ? {24'h0, val[7:0]} : {{24{val[7]}}, val[7:0]};
                end
                else if (nbytes == 2)
                begin
                    e.rdata = r.unsigned_load ? {16'h0, val[15:0]} : {{16{val[15]}}, val[15:0]};
                end
                else
                begin
                    e.rdata = val;
                end
            end
        end
    endtask

    task automatic check_rsp(input mem_pkg::mem_rsp_t exp, input mem_pkg::mem_rsp_t act);
        checks++;
        if (act !== exp)
        begin
            $display("ERR rsp at %0t: expected rdata=%h err=%h, got rdata=%h err=%h",
                     $time, exp.rdata, exp.err, act.rdata, act.err);
            val_errs++;
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            $display("ERR rsp_valid at %0t: expected %h, got %h", $time, exp, act);
            val_errs++;
        end
    endtask

    // one strobed request, then wait for its response
    task automatic send_req(input mem_pkg::mem_req_t r);
        mem_pkg::mem_rsp_t exp;
        int                cnt;
        model_access(r, exp);
        req_valid = 1'b1;
        req       = r;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        cnt       = 0;
        while (rsp_valid !== 1'b1 && cnt < 10)
        begin
            @(posedge clk);
            #2;
            cnt++;
        end
        if (rsp_valid !== 1'b1)
        begin
            $display("No response arrived within 10 cycles for the request at address %h",
                     r.addr);
            lost_rsps++;
        end
        else
        begin
            check_rsp(exp, rsp);
        end
    endtask

    // drains stim_q one request per cycle, each response due in the next cycle
    task automatic run_stream();
        mem_pkg::mem_req_t r;
        mem_pkg::mem_rsp_t exp;
        while (stim_q.size() > 0)
        begin
            r = stim_q.pop_front();
            model_access(r, exp);
            req_valid = 1'b1;
            req       = r;
            @(posedge clk);
            #2;
            check_valid(1'b1, rsp_valid);
            check_rsp(exp, rsp);
        end
        req_valid = 1'b0;
        @(posedge clk);
        #2;
        check_valid(1'b0, rsp_valid);  // pulse ends with the stream
    endtask

    task automatic word_round_trip();
        logic [31:0] addrs [5];
        int          i;
        addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_0200, 32'h0000_03fc};
        for (i = 0; i < 5; i++)
        begin
            send_req(make_req(addrs[i], $urandom(), mem_pkg::size_word, 1'b1, 1'b0));
        end
        for (i = 0; i < 5; i++)
        begin
            send_req(make_req(addrs[i], 32'h0, mem_pkg::size_word, 1'b0, 1'b0));
        end
    endtask

    task automatic lane_merge();
        send_req(make_req(32'h20, 32'h1122_3344, mem_pkg::size_word, 1'b1, 1'b0));
        send_req(make_req(32'h21, 32'hdead_beaa, mem_pkg::size_byte, 1'b1, 1'b0));
        send_req(make_req(32'h22, 32'h5555_ccdd, mem_pkg::size_half, 1'b1, 1'b0));
        send_req(make_req(32'h20, 32'h0, mem_pkg::size_word, 1'b0, 1'b0));
        send_req(make_req(32'h30, 32'h99aa_bbcc, mem_pkg::size_word, 1'b1, 1'b0));
        send_req(make_req(32'h30, 32'hffff_ff11, mem_pkg::size_byte, 1'b1, 1'b0));
        send_req(make_req(32'h33, 32'h0000_0022, mem_pkg::size_byte, 1'b1, 1'b0));
        send_req(make_req(32'h30, 32'h0, mem_pkg::size_word, 1'b0, 1'b0));
    endtask

    task automatic load_extension();
        int off;
        int u;
        send_req(make_req(32'h40, 32'h80f2_7f01, mem_pkg::size_word, 1'b1, 1'b0));
        send_req(make_req(32'h44, 32'h7ffe_8001, mem_pkg::size_word, 1'b1, 1'b0));
        for (u = 0; u < 2; u++)
        begin
            for (off = 0; off < 4; off++)
            begin
                send_req(make_req(32'h40 + off, 32'h0, mem_pkg::size_byte, 1'b0, 1'(u)));
            end
            for (off = 0; off < 8; off += 2)
            begin
                send_req(make_req(32'h40 + off, 32'h0, mem_pkg::size_half, 1'b0, 1'(u)));
            end
        end
    endtask

    task automatic misaligned_access();
        int off;
        send_req(make_req(32'h80, 32'h0bad_f00d, mem_pkg::size_word, 1'b1, 1'b0));
        for (off = 1; off < 4; off++)
        begin
            send_req(make_req(32'h80 + off, 32'hffff_ffff, mem_pkg::size_word, 1'b1, 1'b0));
            send_req(make_req(32'h80 + off, 32'h0, mem_pkg::size_word, 1'b0, 1'b0));
        end
        for (off = 1; off < 4; off += 2)
        begin
            send_req(make_req(32'h80 + off, 32'h0000_1234, mem_pkg::size_half, 1'b1, 1'b0));
            send_req(make_req(32'h80 + off, 32'h0, mem_pkg::size_half, 1'b0, 1'b1));
        end
        send_req(make_req(32'h80, 32'h0, mem_pkg::size_word, 1'b0, 1'b0));  // still intact
    endtask

    task automatic random_stream();
        mem_pkg::mem_req_t r;
        int                i;
        // fill every word first so random loads only see defined lanes
        for (i = 0; i < mem_pkg::RAM_DEPTH; i++)
        begin
            stim_q.push_back(make_req({22'h0, 8'(i), 2'b00},
                                      {8'(i) ^ 8'hc3, 8'(i), ~8'(i), 8'(i) + 8'h17},
                                      mem_pkg::size_word, 1'b1, 1'b0));
        end
        stim_q.push_back(make_req(32'hffff_fc08, 32'h5a5a_0f0f, mem_pkg::size_word, 1'b1, 1'b0));
        stim_q.push_back(make_req(32'h0000_0008, 32'h0, mem_pkg::size_word, 1'b0, 1'b0));
        run_stream();
        for (i = 0; i < 200; i++)
        begin
            r.addr          = $urandom();
            r.wdata         = $urandom();
            r.size          = mem_pkg::mem_size_t'(2'($urandom_range(2, 0)));
            r.write         = 1'($urandom_range(1, 0));
            r.unsigned_load = 1'($urandom_range(1, 0));
            if ($urandom_range(3, 0) != 0)  // most requests aligned
            begin
                if (r.size == mem_pkg::size_half)
                begin
                    r.addr[0] = 1'b0;
                end
                else if (r.size == mem_pkg::size_word)
                begin
                    r.addr[1:0] = 2'b00;
                end
            end
            stim_q.push_back(r);
        end
        run_stream();
    endtask

    initial
    begin
        void'($urandom(20));
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        checks    = 0;
        val_errs  = 0;
        lost_rsps = 0;
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_valid(1'b0, rsp_valid);
        end
        rst_n = 1'b1;
        check_rsp('0, rsp);  // cleared by reset

        word_round_trip();
        lane_merge();
        load_extension();
        misaligned_access();
        random_stream();

        $display("checks %0d, value errors %0d, missing responses %0d",
                 checks, val_errs, lost_rsps);
        if (val_errs == 0 && lost_rsps == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : mem_subsys_tb

// File: verification/mem_subsys_asserts.sv
`timescale 1ns/1ps

module mem_subsys_asserts
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req_valid,
    input mem_pkg::mem_lane_req_t lane_req,
    input logic [3:0]             ram_we,
    input logic                   rsp_valid
);

    // a request is answered in exactly the next cycle
    a_rsp_after_req : assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |=> rsp_valid)
        else $error("rsp_valid missing one cycle after req_valid");

    a_no_rsp_without_req : assert property (@(posedge clk) disable iff (!rst_n)
        !req_valid |=> !rsp_valid)
        else $error("rsp_valid high without a request in the previous cycle");

    // misaligned stores never reach the banks
    a_misaligned_no_write : assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && lane_req.misaligned) |-> (ram_we == 4'b0000))
        else $error("bank write enabled on a misaligned request");

    a_quiet_in_reset : assert property (@(posedge clk)
        !rst_n |=> !rsp_valid)
        else $error("rsp_valid high during reset");

endmodule : mem_subsys_asserts

bind mem_subsys_top mem_subsys_asserts u_asserts
(
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .lane_req  (lane_req),
    .ram_we    (ram_we),
    .rsp_valid (rsp_valid)
);

// File: source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,  // one request per cycle, no back-pressure
    input  mem_pkg::mem_req_t req,
    output logic              rsp_valid,  // pulses the cycle after req_valid
    output mem_pkg::mem_rsp_t rsp
);

    mem_pkg::mem_lane_req_t lane_req;  // decoded request
    logic [3:0]             ram_we;    // gated lane enables
    logic [31:0]            rd_lanes;  // raw read word

    // only a valid store reaches the banks
    assign ram_we = lane_req.be & {4{req_valid & req.write}};

    mem_req_align u_req_align
    (
        .req       (req),
        .lane_req  (lane_req)
    );

    mem_banked_ram u_ram
    (
        .clk       (clk),
        .index     (lane_req.index),
        .we        (ram_we),
        .wd        (lane_req.lane_data),
        .rd        (rd_lanes)
    );

    mem_load_align u_load_align
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .write         (req.write),
        .size          (req.size),
        .unsigned_load (req.unsigned_load),
        .offset        (req.addr[1:0]),
        .misaligned    (lane_req.misaligned),
        .rd_lanes      (rd_lanes),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

endmodule : mem_subsys_top

// File: source/mem_load_align.sv
`timescale 1ns/1ps

module mem_load_align
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               write,
    input  mem_pkg::mem_size_t size,
    input  logic               unsigned_load,
    input  logic [1:0]         offset,         // byte offset of the access
    input  logic               misaligned,
    input  logic [31:0]        rd_lanes,       // raw word from the banks
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp
);

    logic [7:0]  byte_sel;   // addressed byte
    logic [15:0] half_sel;   // addressed half
    logic        fill;       // extension bit
    logic [31:0] load_data;  // extended load value
    logic [31:0] rdata_nxt;

    // lane selection
    always_comb
    begin
        byte_sel = rd_lanes[{offset, 3'b000} +: 8];
        half_sel = offset[1] ? rd_lanes[31:16] : rd_lanes[15:0];
    end

    // sign or zero extension
    always_comb
    begin
        case (size)
            mem_pkg::size_byte:
            begin
                fill      = ~unsigned_load & byte_sel[7];
                load_data = {{24{fill}}, byte_sel};
            end
            mem_pkg::size_half:
            begin
                fill      = ~unsigned_load & half_sel[15];
                load_data = {{16{fill}}, half_sel};
            end
            default:
            begin
                fill      = 1'b0;  // full word, nothing to extend
                load_data = rd_lanes;
            end
        endcase
    end

    // stores and faulting accesses return zero data
    assign rdata_nxt = (write || misaligned) ? 32'h0 : load_data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end
        else
        begin
            rsp_valid <= req_valid;  // single-cycle pulse per request
            if (req_valid)
            begin
                rsp.rdata <= rdata_nxt;
                rsp.err   <= misaligned;
            end
        end
    end

endmodule : mem_load_align

// File: source/mem_banked_ram.sv
`timescale 1ns/1ps

module mem_banked_ram
(
    input  logic                          clk,
    input  logic [mem_pkg::RAM_IDX_W-1:0] index,  // word index
    input  logic [3:0]                    we,     // per-lane write enables
    input  logic [31:0]                   wd,     // lane-positioned write data
    output logic [31:0]                   rd      // combinational read data
);

    // One byte-wide bank per lane. Each bank has its own write enable,
    // so byte and half stores touch only the addressed lanes while a
    // read always returns the whole word at the index.
    for (genvar lane = 0; lane < 4; lane++)
    begin : g_bank
        logic [7:0] bank [mem_pkg::RAM_DEPTH];  // no reset, contents start undefined

        always_ff @(posedge clk)
        begin
            if (we[lane])
            begin
                bank[index] <= wd[lane*8 +: 8];  // commit at the end of the request cycle
            end
        end

        assign rd[lane*8 +: 8] = bank[index];  // async read
    end

endmodule : mem_banked_ram

// File: source/mem_req_align.sv
`timescale 1ns/1ps

module mem_req_align
(
    input  mem_pkg::mem_req_t      req,
    output mem_pkg::mem_lane_req_t lane_req
);

    logic [1:0]                    offset;      // byte offset within the word
    logic                          misaligned;
    logic [3:0]                    be_raw;      // enables before the alignment check
    logic [31:0]                   lane_data;
    logic [mem_pkg::RAM_IDX_W-1:0] index;

    assign offset = req.addr[1:0];
    assign index  = req.addr[mem_pkg::RAM_IDX_W+1:2];  // upper bits ignored, address wraps

    // alignment check
    always_comb
    begin
        case (req.size)
            mem_pkg::size_byte:
            begin
                misaligned = 1'b0;  // bytes are always aligned
            end
            mem_pkg::size_half:
            begin
                misaligned = offset[0];
            end
            default:
            begin
                misaligned = |offset;  // word, or an unused size code
            end
        endcase
    end

    // lane enables from size and offset
    always_comb
    begin
        case (req.size)
            mem_pkg::size_byte:
            begin
                be_raw = 4'b0001 << offset;
            end
            mem_pkg::size_half:
            begin
                be_raw = offset[1] ? 4'b1100 : 4'b0011;  // upper or lower half
            end
            default:
            begin
                be_raw = 4'b1111;
            end
        endcase
    end

    // store data copied into every lane it could land in;
    // the enables pick which copy is actually written
    always_comb
    begin
        case (req.size)
            mem_pkg::size_byte:
            begin
                lane_data = {4{req.wdata[7:0]}};
            end
            mem_pkg::size_half:
            begin
                lane_data = {2{req.wdata[15:0]}};
            end
            default:
            begin
                lane_data = req.wdata;
            end
        endcase
    end

    always_comb
    begin
        lane_req.index      = index;
        lane_req.be         = misaligned ? 4'b0000 : be_raw;  // never write on misalignment
        lane_req.lane_data  = lane_data;
        lane_req.misaligned = misaligned;
    end

endmodule : mem_req_align

// File: source/mem_pkg.sv
package mem_pkg;

    // data memory geometry
    localparam int RAM_DEPTH = 256;                // number of 32-bit words
    localparam int RAM_IDX_W = $clog2(RAM_DEPTH);  // word index width

    // access width of a core-side request
    typedef enum logic [1:0]
    {
        size_byte = 2'd0,  // lb / lbu / sb
        size_half = 2'd1,  // lh / lhu / sh
        size_word = 2'd2   // lw / sw
    } mem_size_t;

    // request as issued by the core
    typedef struct packed
    {
        logic [31:0] addr;           // byte address
        logic [31:0] wdata;          // store data, right-aligned
        mem_size_t   size;           // access width
        logic        write;          // 1 = store, 0 = load
        logic        unsigned_load;  // zero-extend instead of sign-extend
    } mem_req_t;

    // request after lane decoding
    typedef struct packed
    {
        logic [RAM_IDX_W-1:0] index;      // word index into the banks
        logic [3:0]           be;         // per-lane byte enables
        logic [31:0]          lane_data;  // store data placed in lanes
        logic                 misaligned; // access crosses its natural boundary
    } mem_lane_req_t;

    // registered response back to the core
    typedef struct packed
    {
        logic [31:0] rdata;  // formatted load data, zero for stores and errors
        logic        err;    // misaligned access
    } mem_rsp_t;

endpackage : mem_pkg
